/* verilog/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [3:0]  nibble_t;
    typedef logic [11:0] opcode_t;
    typedef logic [12:0] pc_t;
    typedef logic [11:0] addr_t;
    typedef logic [7:0]  sp_t;

    // Opcode field patterns
    localparam logic [5:0] OPC_LD_IMM = 6'b1110_00;  // E0r i, opcode[11:6]
    localparam logic [3:0] OPC_LD_X   = 4'hB;        // B ee
    localparam logic [3:0] OPC_LD_Y   = 4'h8;        // 8 ee
    localparam logic [3:0] OPC_JP     = 4'h0;        // 0 ss
    localparam logic [7:0] OPC_PUSH   = 8'hFC;       // FC n
    localparam logic [7:0] OPC_POP    = 8'hFD;       // FD n

    typedef enum logic [2:0] {
        STEP_FETCH,
        STEP_DECODE,
        STEP_ADDR,
        STEP_READ,
        STEP_WRITE
    } step_e;

    typedef enum logic [2:0] {
        OP_NOP,
        OP_LD_IMM,
        OP_LD_X,
        OP_LD_Y,
        OP_PUSH,
        OP_POP,
        OP_JP
    } op_kind_e;

    // Encoded as the low nibble of PUSH and POP
    typedef enum logic [3:0] {
        LOC_A,
        LOC_B,
        LOC_MX,
        LOC_MY,
        LOC_XP,
        LOC_XH,
        LOC_XL,
        LOC_YP,
        LOC_YH,
        LOC_YL,
        LOC_F
    } loc_e;

    typedef struct packed {
        logic i;
        logic d;
        logic z;
        logic c;
    } flags_t;

    typedef struct packed {
        op_kind_e   op_kind;
        loc_e       loc;
        logic [7:0] imm;
        logic       needs_read;   // Source or POP comes from RAM
    } ctrl_t;

    typedef struct packed {
        addr_t x;
        addr_t y;
        sp_t   sp;
    } ptr_t;

    typedef struct packed {
        logic       reg_we;
        loc_e       loc;
        nibble_t    data;
        logic       byte_we;      // H and L pair
        logic       byte_sel;     // 0 X, 1 Y
        logic [7:0] byte_data;
        logic       sp_inc;
        logic       sp_dec;
    } wb_t;

endpackage

/* verilog/instr_decode.sv */
module instr_decode (
    input  cpu_pkg::opcode_t opcode,
    output cpu_pkg::ctrl_t   ctrl
);

    logic [5:0] field_ld;
    logic [3:0] field_hi;
    logic [7:0] field_stk;
    logic [3:0] field_lo;
    logic [1:0] field_r;
    logic       stack_loc_ok;
    logic       is_mem_loc;

    assign field_ld  = opcode[11:6];
    assign field_hi  = opcode[11:8];
    assign field_stk = opcode[11:4];
    assign field_lo  = opcode[3:0];
    assign field_r   = opcode[5:4];

    // FCB..FCF and FDB..FDF fall through to NOP
    assign stack_loc_ok = field_lo <= 4'(cpu_pkg::LOC_F);

    // Stack operand field names M(X) or M(Y)
    assign is_mem_loc = (field_lo == 4'(cpu_pkg::LOC_MX)) || (field_lo == 4'(cpu_pkg::LOC_MY));

    always_comb begin
        ctrl         = '0;
        ctrl.op_kind = cpu_pkg::OP_NOP;
        ctrl.loc     = cpu_pkg::LOC_A;
        ctrl.imm     = opcode[7:0];

        if (field_ld == cpu_pkg::OPC_LD_IMM) begin
            ctrl.op_kind = cpu_pkg::OP_LD_IMM;
            ctrl.loc     = cpu_pkg::loc_e'({2'b00, field_r});
            ctrl.imm     = {4'h0, field_lo};
        end else if (field_hi == cpu_pkg::OPC_LD_X) begin
            ctrl.op_kind = cpu_pkg::OP_LD_X;
        end else if (field_hi == cpu_pkg::OPC_LD_Y) begin
            ctrl.op_kind = cpu_pkg::OP_LD_Y;
        end else if (field_hi == cpu_pkg::OPC_JP) begin
            ctrl.op_kind = cpu_pkg::OP_JP;
        end else if (field_stk == cpu_pkg::OPC_PUSH && stack_loc_ok) begin
            ctrl.op_kind = cpu_pkg::OP_PUSH;
            ctrl.loc     = cpu_pkg::loc_e'(field_lo);
        end else if (field_stk == cpu_pkg::OPC_POP && stack_loc_ok) begin
            ctrl.op_kind = cpu_pkg::OP_POP;
            ctrl.loc     = cpu_pkg::loc_e'(field_lo);
        end

        ctrl.needs_read = (ctrl.op_kind == cpu_pkg::OP_POP) ||
                          (ctrl.op_kind == cpu_pkg::OP_PUSH && is_mem_loc);
    end

    // Opcode is undefined until the first fetch
    always_comb begin
        if (!$isunknown(opcode)) begin
            assert (ctrl.loc <= cpu_pkg::LOC_F)
                else $error("decoded location out of range");
            assert (!(ctrl.op_kind == cpu_pkg::OP_LD_IMM && ctrl.loc >= cpu_pkg::LOC_XP))
                else $error("immediate load to a pointer or flag nibble");
        end
    end

endmodule

/* verilog/cpu_regs.sv */
module cpu_regs (
    input  logic             clk,
    input  logic             arst_n,
    input  cpu_pkg::wb_t     wb,
    input  cpu_pkg::loc_e    loc,
    output cpu_pkg::ptr_t    ptrs,
    output cpu_pkg::nibble_t src_data
);

    cpu_pkg::nibble_t a;
    cpu_pkg::nibble_t b;
    cpu_pkg::addr_t   x;
    cpu_pkg::addr_t   y;
    cpu_pkg::sp_t     sp;
    cpu_pkg::flags_t  f;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a <= '0;
            b <= '0;
            f <= '0;
        end else if (wb.reg_we) begin
            case (wb.loc)
                cpu_pkg::LOC_A: a <= wb.data;
                cpu_pkg::LOC_B: b <= wb.data;
                cpu_pkg::LOC_F: f <= cpu_pkg::flags_t'(wb.data);  // I D Z C
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x <= '0;
            y <= '0;
        end else begin
            if (wb.byte_we) begin
                if (wb.byte_sel) begin
                    y[7:0] <= wb.byte_data;
                end else begin
                    x[7:0] <= wb.byte_data;
                end
            end
            if (wb.reg_we) begin
                case (wb.loc)
                    cpu_pkg::LOC_XP: x[11:8] <= wb.data;
                    cpu_pkg::LOC_XH: x[7:4]  <= wb.data;
                    cpu_pkg::LOC_XL: x[3:0]  <= wb.data;
                    cpu_pkg::LOC_YP: y[11:8] <= wb.data;
                    cpu_pkg::LOC_YH: y[7:4]  <= wb.data;
                    cpu_pkg::LOC_YL: y[3:0]  <= wb.data;
                    default: ;
                endcase
            end
        end
    end

    // SP moves regardless of the nibble write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sp <= '0;
        end else if (wb.sp_inc) begin
            sp <= sp + cpu_pkg::sp_t'(1);
        end else if (wb.sp_dec) begin
            sp <= sp - cpu_pkg::sp_t'(1);
        end
    end

    assign ptrs.x  = x;
    assign ptrs.y  = y;
    assign ptrs.sp = sp;

    always_comb begin
        case (loc)
            cpu_pkg::LOC_A:  src_data = a;
            cpu_pkg::LOC_B:  src_data = b;
            cpu_pkg::LOC_XP: src_data = x[11:8];
            cpu_pkg::LOC_XH: src_data = x[7:4];
            cpu_pkg::LOC_XL: src_data = x[3:0];
            cpu_pkg::LOC_YP: src_data = y[11:8];
            cpu_pkg::LOC_YH: src_data = y[7:4];
            cpu_pkg::LOC_YL: src_data = y[3:0];
            cpu_pkg::LOC_F:  src_data = cpu_pkg::nibble_t'(f);
            default:         src_data = '0;  // M(X), M(Y) come from RAM
        endcase
    end

    // Sequencer must never ask for both directions at once
    a_sp_one_way: assert property (
        @(posedge clk) disable iff (!arst_n) !(wb.sp_inc && wb.sp_dec)
    ) else $error("sp_inc and sp_dec both set");

endmodule

/* verilog/cpu_sequencer.sv */
module cpu_sequencer #(
    parameter cpu_pkg::pc_t reset_pc   = '0,
    parameter logic [3:0]   stack_page = 4'h0
) (
    input  logic             clk,
    input  logic             arst_n,
    input  cpu_pkg::ctrl_t   ctrl,
    input  cpu_pkg::ptr_t    ptrs,
    input  cpu_pkg::nibble_t src_data,
    output cpu_pkg::opcode_t opcode,
    output cpu_pkg::loc_e    loc,
    output cpu_pkg::wb_t     wb,
    output cpu_pkg::pc_t     rom_addr,
    input  cpu_pkg::opcode_t rom_data,
    output cpu_pkg::addr_t   ram_addr,
    output cpu_pkg::nibble_t ram_wdata,
    input  cpu_pkg::nibble_t ram_rdata,
    output logic             ram_we
);

    cpu_pkg::step_e   step;
    cpu_pkg::pc_t     pc;
    cpu_pkg::ctrl_t   ctrl_q;
    cpu_pkg::nibble_t rdata_q;
    cpu_pkg::pc_t     next_pc;
    cpu_pkg::sp_t     push_sp;
    cpu_pkg::addr_t   ptr_addr;
    cpu_pkg::addr_t   rd_addr;
    cpu_pkg::addr_t   wr_addr;
    cpu_pkg::nibble_t wr_data;
    logic             is_mem_loc;
    logic             in_write;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            step   <= cpu_pkg::STEP_FETCH;
            pc     <= reset_pc;
            ctrl_q <= '0;
        end else begin
            case (step)
                cpu_pkg::STEP_FETCH:  step <= cpu_pkg::STEP_DECODE;
                cpu_pkg::STEP_DECODE: begin
                    step   <= cpu_pkg::STEP_ADDR;
                    ctrl_q <= ctrl;
                end
                cpu_pkg::STEP_ADDR:   step <= cpu_pkg::STEP_READ;
                cpu_pkg::STEP_READ:   step <= cpu_pkg::STEP_WRITE;
                cpu_pkg::STEP_WRITE: begin
                    step <= cpu_pkg::STEP_FETCH;
                    pc   <= next_pc;
                end
                default:              step <= cpu_pkg::STEP_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (step == cpu_pkg::STEP_FETCH) begin
            opcode <= rom_data;
        end
        if (step == cpu_pkg::STEP_READ) begin
            rdata_q <= ram_rdata;  // Sync RAM answers one cycle after ADDR
        end
    end

    assign next_pc = (ctrl_q.op_kind == cpu_pkg::OP_JP) ? {pc[12:8], ctrl_q.imm}
                                                        : pc + cpu_pkg::pc_t'(1);

    assign in_write   = step == cpu_pkg::STEP_WRITE;
    assign is_mem_loc = (ctrl_q.loc == cpu_pkg::LOC_MX) || (ctrl_q.loc == cpu_pkg::LOC_MY);
    assign push_sp    = ptrs.sp - cpu_pkg::sp_t'(1);
    assign ptr_addr   = (ctrl_q.loc == cpu_pkg::LOC_MY) ? ptrs.y : ptrs.x;

    assign rd_addr = (ctrl_q.op_kind == cpu_pkg::OP_POP) ? {stack_page, ptrs.sp} : ptr_addr;
    assign wr_addr = (ctrl_q.op_kind == cpu_pkg::OP_PUSH) ? {stack_page, push_sp} : ptr_addr;

    assign wr_data = (ctrl_q.op_kind == cpu_pkg::OP_LD_IMM) ? ctrl_q.imm[3:0] :
                     ctrl_q.needs_read                      ? rdata_q         :
                                                              src_data;

    assign rom_addr  = pc;
    assign ram_addr  = in_write ? wr_addr : rd_addr;
    assign ram_wdata = wr_data;
    assign ram_we    = in_write &&
                       ((ctrl_q.op_kind == cpu_pkg::OP_PUSH) ||
                        (is_mem_loc && (ctrl_q.op_kind == cpu_pkg::OP_LD_IMM ||
                                        ctrl_q.op_kind == cpu_pkg::OP_POP)));

    assign loc = ctrl_q.loc;

    assign wb.reg_we    = in_write && !is_mem_loc &&
                          (ctrl_q.op_kind == cpu_pkg::OP_LD_IMM ||
                           ctrl_q.op_kind == cpu_pkg::OP_POP);
    assign wb.loc       = ctrl_q.loc;
    assign wb.data      = wr_data;
    assign wb.byte_we   = in_write && (ctrl_q.op_kind == cpu_pkg::OP_LD_X ||
                                       ctrl_q.op_kind == cpu_pkg::OP_LD_Y);
    assign wb.byte_sel  = ctrl_q.op_kind == cpu_pkg::OP_LD_Y;
    assign wb.byte_data = ctrl_q.imm;
    assign wb.sp_inc    = in_write && (ctrl_q.op_kind == cpu_pkg::OP_POP);
    assign wb.sp_dec    = in_write && (ctrl_q.op_kind == cpu_pkg::OP_PUSH);

    a_we_in_write: assert property (
        @(posedge clk) disable iff (!arst_n) ram_we |-> step == cpu_pkg::STEP_WRITE
    ) else $error("RAM write outside the write step");

    a_wrap: assert property (
        @(posedge clk) disable iff (!arst_n)
        step == cpu_pkg::STEP_WRITE |=> step == cpu_pkg::STEP_FETCH
    ) else $error("write step not followed by fetch");

    // Every other step advances by exactly one
    a_no_skip: assert property (
        @(posedge clk) disable iff (!arst_n)
        step != cpu_pkg::STEP_WRITE |=> int'(step) == int'($past(step)) + 1
    ) else $error("step sequence skipped a state");

endmodule

/* verilog/cpu_top.sv */
module cpu_top #(
    parameter cpu_pkg::pc_t reset_pc   = 13'h0100,
    parameter logic [3:0]   stack_page = 4'h0
) (
    input  logic             clk,
    input  logic             arst_n,
    output cpu_pkg::pc_t     rom_addr,
    input  cpu_pkg::opcode_t rom_data,
    output cpu_pkg::addr_t   ram_addr,
    output cpu_pkg::nibble_t ram_wdata,
    input  cpu_pkg::nibble_t ram_rdata,
    output logic             ram_we
);

    cpu_pkg::opcode_t opcode;
    cpu_pkg::ctrl_t   ctrl;
    cpu_pkg::ptr_t    ptrs;
    cpu_pkg::nibble_t src_data;
    cpu_pkg::loc_e    loc;
    cpu_pkg::wb_t     wb;

    instr_decode u_decode (
        .opcode (opcode),
        .ctrl   (ctrl)
    );

    cpu_sequencer #(
        .reset_pc   (reset_pc),
        .stack_page (stack_page)
    ) u_seq (
        .clk       (clk),
        .arst_n    (arst_n),
        .ctrl      (ctrl),
        .ptrs      (ptrs),
        .src_data  (src_data),
        .opcode    (opcode),
        .loc       (loc),
        .wb        (wb),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata),
        .ram_we    (ram_we)
    );

    cpu_regs u_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb       (wb),
        .loc      (loc),
        .ptrs     (ptrs),
        .src_data (src_data)
    );

endmodule

/* dv/cpu_tb.sv */
module cpu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam cpu_pkg::pc_t boot_pc      = 13'h0100;
    localparam logic [3:0]   stk_page     = 4'h3;
    localparam int           clk_period   = 20;
    localparam int           reset_cycles = 8;
    localparam int           total_instr  = 69;  // Sum over all tests below
    localparam int           num_resets   = 11;
    localparam int           limit_ns     =
        (total_instr * 5 + num_resets * reset_cycles) * clk_period * 2;

    logic             clk       = 1'b0;
    logic             arst_n    = 1'b0;
    cpu_pkg::pc_t     rom_addr;
    cpu_pkg::opcode_t rom_data;
    cpu_pkg::addr_t   ram_addr;
    cpu_pkg::nibble_t ram_wdata;
    cpu_pkg::nibble_t ram_rdata = '0;
    logic             ram_we;

    cpu_pkg::opcode_t rom [0:8191];
    cpu_pkg::nibble_t ram [0:4095];
    cpu_pkg::addr_t   log_addr [$];
    cpu_pkg::nibble_t log_data [$];
    cpu_pkg::addr_t   exp_addr [$];
    cpu_pkg::nibble_t exp_data [$];
    cpu_pkg::pc_t     load_pc;
    integer           seed;
    int               errors = 0;

    cpu_top #(
        .reset_pc   (boot_pc),
        .stack_page (stk_page)
    ) UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata),
        .ram_we    (ram_we)
    );

    always #(clk_period / 2) clk = ~clk;

    assign rom_data = rom[rom_addr];  // Async ROM

    always @(posedge clk) begin
        ram_rdata <= ram[ram_addr];
        if (arst_n && ram_we) begin
            ram[ram_addr] <= ram_wdata;
            log_addr.push_back(ram_addr);
            log_data.push_back(ram_wdata);
        end
    end

    task automatic end_with_failure();
        errors++;
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_eq(input string test, input string what,
                            input logic [15:0] exp, input logic [15:0] act);
        assert (exp === act) else begin
            $display("ERROR %s: %s expected %h actual %h", test, what, exp, act);
            end_with_failure();
        end
    endtask

    function automatic cpu_pkg::nibble_t rand_nibble();
        return cpu_pkg::nibble_t'($random(seed));
    endfunction

    function automatic logic [7:0] rand_byte();
        return 8'($random(seed));
    endfunction

    function automatic cpu_pkg::opcode_t ld_imm_op(input logic [1:0] r,
                                                   input cpu_pkg::nibble_t i);
        return {6'b1110_00, r, i};  // r is A, B, MX, MY
    endfunction

    function automatic cpu_pkg::opcode_t push_op(input cpu_pkg::loc_e n);
        return {8'hFC, 4'(n)};
    endfunction

    function automatic cpu_pkg::opcode_t pop_op(input cpu_pkg::loc_e n);
        return {8'hFD, 4'(n)};
    endfunction

    task automatic emit(input cpu_pkg::opcode_t op);
        rom[load_pc] = op;
        load_pc = load_pc + 13'd1;
    endtask

    task automatic expect_write(input cpu_pkg::addr_t addr, input cpu_pkg::nibble_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // Hold reset, refill memories and clear the write log
    task automatic start_test();
        int a;
        arst_n = 1'b0;
        for (a = 0; a < 8192; a++) begin
            rom[a] = {4'h9, 8'(a) ^ 8'(a >> 8)};  // 9xx is not a defined opcode
        end
        for (a = 0; a < 4096; a++) begin
            ram[a] = 4'(a) ^ 4'(a >> 4) ^ 4'(a >> 8) ^ 4'h5;
        end
        log_addr.delete();
        log_data.delete();
        exp_addr.delete();
        exp_data.delete();
        load_pc = boot_pc;
    endtask

    task automatic release_reset();
        repeat (reset_cycles) @(negedge clk);
        arst_n = 1'b1;
    endtask

    task automatic run_instr(input int n);
        repeat (n * 5) @(negedge clk);
    endtask

    task automatic step_instr(input string test, input cpu_pkg::pc_t exp_pc);
        repeat (5) @(negedge clk);
        check_eq(test, "rom_addr", 16'(exp_pc), 16'(rom_addr));
    endtask

    task automatic check_writes(input string test);
        int k;
        check_eq(test, "RAM write count", 16'(exp_addr.size()), 16'(log_addr.size()));
        for (k = 0; k < exp_addr.size(); k++) begin
            check_eq(test, $sformatf("write %0d address", k), 16'(exp_addr[k]), 16'(log_addr[k]));
            check_eq(test, $sformatf("write %0d data", k), 16'(exp_data[k]), 16'(log_data[k]));
        end
    endtask

    task automatic test_reset_nop();
        int c;
        start_test();
        emit(12'hFFB);
        emit(12'h5A3);
        release_reset();
        for (c = 0; c < 30; c++) begin
            check_eq("reset_nop", "rom_addr", 16'(boot_pc + cpu_pkg::pc_t'(c / 5)), 16'(rom_addr));
            check_eq("reset_nop", "ram_we", 16'h0, 16'(ram_we));
            @(negedge clk);
        end
        check_eq("reset_nop", "rom_addr", 16'(boot_pc + 13'd6), 16'(rom_addr));
        check_writes("reset_nop");
    endtask

    task automatic test_push_ab();
        cpu_pkg::nibble_t va;
        cpu_pkg::nibble_t vb;
        va = rand_nibble();
        vb = ~va;  // Keeps the two sources apart
        start_test();
        emit(ld_imm_op(2'd0, va));
        emit(ld_imm_op(2'd1, vb));
        emit(push_op(cpu_pkg::LOC_A));
        emit(push_op(cpu_pkg::LOC_B));
        expect_write({stk_page, 8'hFF}, va);  // SP pre-decrements from zero
        expect_write({stk_page, 8'hFE}, vb);
        release_reset();
        run_instr(4);
        check_writes("push_ab");
    endtask

    task automatic test_mem_x();
        logic [7:0]       e;
        cpu_pkg::nibble_t i1;
        cpu_pkg::nibble_t i2;
        e  = rand_byte();
        i1 = rand_nibble();
        i2 = ~i1;
        start_test();
        emit({4'hB, e});
        emit(ld_imm_op(2'd2, i1));
        emit(ld_imm_op(2'd0, i2));
        emit(push_op(cpu_pkg::LOC_A));
        emit(pop_op(cpu_pkg::LOC_MX));
        emit(push_op(cpu_pkg::LOC_MX));
        expect_write({4'h0, e}, i1);
        expect_write({stk_page, 8'hFF}, i2);
        expect_write({4'h0, e}, i2);        // POP MX
        expect_write({stk_page, 8'hFF}, i2);  // PUSH MX reads back from X
        release_reset();
        run_instr(6);
        check_writes("mem_x");
    endtask

    // Pop into one nibble of X or Y, then push all three
    task automatic test_ptr_nibble(input logic is_y, input int which);
        string            test;
        logic [7:0]       e;
        cpu_pkg::nibble_t v;
        logic [3:0]       base;
        logic [11:0]      ptr;
        test = $sformatf("ptr_%s%s", is_y ? "y" : "x",
                         (which == 0) ? "p" : (which == 1) ? "h" : "l");
        e    = rand_byte();
        v    = rand_nibble();
        base = is_y ? 4'(cpu_pkg::LOC_YP) : 4'(cpu_pkg::LOC_XP);
        ptr  = {4'h0, e};
        if (v == ptr[11 - 4 * which -: 4]) begin
            v = ~v;  // Popped nibble must differ from the old one
        end
        ptr[11 - 4 * which -: 4] = v;
        start_test();
        emit(is_y ? {4'h8, e} : {4'hB, e});
        emit(ld_imm_op(2'd0, v));
        emit(push_op(cpu_pkg::LOC_A));
        emit(pop_op(cpu_pkg::loc_e'(base + 4'(which))));
        emit(push_op(cpu_pkg::loc_e'(base)));
        emit(push_op(cpu_pkg::loc_e'(base + 4'd1)));
        emit(push_op(cpu_pkg::loc_e'(base + 4'd2)));
        expect_write({stk_page, 8'hFF}, v);
        expect_write({stk_page, 8'hFF}, ptr[11:8]);
        expect_write({stk_page, 8'hFE}, ptr[7:4]);
        expect_write({stk_page, 8'hFD}, ptr[3:0]);
        release_reset();
        run_instr(7);
        check_writes(test);
    endtask

    task automatic test_flags();
        cpu_pkg::nibble_t f;
        f = rand_nibble();
        if (f == 4'h0) begin
            f = ~f;  // F is zero after reset
        end
        start_test();
        emit(ld_imm_op(2'd0, f));
        emit(push_op(cpu_pkg::LOC_A));
        emit(ld_imm_op(2'd0, ~f));  // A no longer holds f
        emit(pop_op(cpu_pkg::LOC_F));
        emit(push_op(cpu_pkg::LOC_F));
        emit(push_op(cpu_pkg::LOC_A));
        expect_write({stk_page, 8'hFF}, f);
        expect_write({stk_page, 8'hFF}, f);  // SP back where it was
        expect_write({stk_page, 8'hFE}, ~f);
        release_reset();
        run_instr(6);
        check_writes("flags");
    endtask

    task automatic test_jump();
        logic [7:0]       b;
        logic [7:0]       s;
        cpu_pkg::pc_t     target;
        cpu_pkg::nibble_t v;
        b      = rand_byte();
        s      = 8'h20 + {1'b0, b[6:0]};
        target = {boot_pc[12:8], s};
        v      = rand_nibble();
        start_test();
        emit({4'h0, s});
        load_pc = target;
        emit(ld_imm_op(2'd0, v));
        emit(12'hFCF);  // PUSH of a location that does not exist
        emit(12'h5A3);
        emit(push_op(cpu_pkg::LOC_A));
        expect_write({stk_page, 8'hFF}, v);
        release_reset();
        step_instr("jump", target);
        step_instr("jump", target + 13'd1);
        step_instr("jump", target + 13'd2);
        step_instr("jump", target + 13'd3);
        step_instr("jump", target + 13'd4);
        check_writes("jump");
    endtask

    initial begin
        #(limit_ns);
        $display("Timeout: the tests did not finish within %0d ns", limit_ns);
        end_with_failure();
    end

    initial begin
        seed = 32'h92dd_6de8;
        test_reset_nop();
        test_push_ab();
        test_mem_x();
        test_ptr_nibble(1'b0, 0);
        test_ptr_nibble(1'b0, 1);
        test_ptr_nibble(1'b0, 2);
        test_ptr_nibble(1'b1, 0);
        test_ptr_nibble(1'b1, 1);
        test_ptr_nibble(1'b1, 2);
        test_flags();
        test_jump();
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
verilog/cpu_pkg.sv
verilog/instr_decode.sv
verilog/cpu_regs.sv
verilog/cpu_sequencer.sv
verilog/cpu_top.sv
dv/cpu_tb.sv

/* Makefile */
# Verilator build and run of the CPU testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
